// File: src/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ==================================================
// Fetch front end configuration
// ==================================================

`define FETCH_RESET_PC   32'h8000_0000  // First fetch address after reset.

`define FETCH_XLEN       32             // Width of the PC and of one instruction.

// Occupancy of the multiply and divide units, counted in clocks.
`define FETCH_MUL_CYCLES 3              // Multiply occupancy.
`define FETCH_DIV_CYCLES 8              // Divide occupancy.

`endif

// File: src/fetch_pkg.sv
package fetch_pkg;

    // ==================================================
    // Opcodes seen by the fetch unit
    // ==================================================

    localparam logic [6:0] OPC_OP    = 7'b0110011;  // Register-register ALU group.
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // Marks the M extension in OPC_OP.

    // ==================================================
    // Instruction word views
    // ==================================================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // The J-immediate is rebuilt from the I-format fields, since its bits
    // sit in imm12, rs1 and funct3.
    typedef union packed {
        r_fmt_t r_fmt;  // Used for the M extension check.
        i_fmt_t i_fmt;  // Used for the JAL and JALR offsets.
    } instr_u;

    // ==================================================
    // Decode classes
    // ==================================================

    typedef enum logic [2:0] {
        PLAIN = 3'd0,
        MUL   = 3'd1,
        DIV   = 3'd2,
        JAL   = 3'd3,
        JALR  = 3'd4
    } instr_class_e;

endpackage

// File: src/fetch_if.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

interface fetch_if;
    logic                   fetch_go;     // One-cycle request to open a read.
    logic [`FETCH_XLEN-1:0] fetch_pc;
    logic                   fetch_done;   // One pulse per completed read.
    logic [`FETCH_XLEN-1:0] fetch_instr;  // Valid while fetch_done is high.

    modport seq  (output fetch_go, fetch_pc, input fetch_done, fetch_instr);
    modport port (input fetch_go, fetch_pc, output fetch_done, fetch_instr);
endinterface

interface muldiv_if;
    logic start_mul;
    logic start_div;
    logic busy;
    logic finish;     // Pulses one cycle after the count runs out.

    modport seq   (output start_mul, start_div, input busy, finish);
    modport timer (input start_mul, start_div, output busy, finish);
endinterface

// File: src/fetch_decode.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_decode (
    input  fetch_pkg::instr_u        instr,
    input  logic [`FETCH_XLEN-1:0]   pc,
    input  logic [`FETCH_XLEN-1:0]   jalr_base,
    output fetch_pkg::instr_class_e  cls,
    output logic [`FETCH_XLEN-1:0]   jal_target,
    output logic [`FETCH_XLEN-1:0]   jalr_target
);

    logic                   is_m_ext;
    logic [`FETCH_XLEN-1:0] j_imm;
    logic [`FETCH_XLEN-1:0] i_imm;
    logic [`FETCH_XLEN-1:0] jalr_sum;

    // ==================================================
    // Classification
    // ==================================================

    assign is_m_ext = (instr.r_fmt.opcode == fetch_pkg::OPC_OP) &&
                      (instr.r_fmt.funct7 == fetch_pkg::F7_MULDIV);

    always_comb begin
        cls = fetch_pkg::PLAIN;
        if (instr.r_fmt.opcode == fetch_pkg::OPC_JAL) begin
            cls = fetch_pkg::JAL;
        end else if (instr.r_fmt.opcode == fetch_pkg::OPC_JALR) begin
            cls = fetch_pkg::JALR;
        end else if (is_m_ext) begin
            // funct3 of 4 and up covers div, divu, rem and remu.
            cls = instr.r_fmt.funct3[2] ? fetch_pkg::DIV : fetch_pkg::MUL;
        end
    end

    // ==================================================
    // Jump targets
    // ==================================================

    // J-immediate order is imm[20], imm[10:1], imm[11], imm[19:12].
    assign j_imm = {{(`FETCH_XLEN-20){instr.i_fmt.imm12[11]}},
                    instr.i_fmt.rs1,
                    instr.i_fmt.funct3,
                    instr.i_fmt.imm12[0],
                    instr.i_fmt.imm12[10:1],
                    1'b0};

    assign i_imm = {{(`FETCH_XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};

    assign jal_target = pc + j_imm;

    assign jalr_sum    = jalr_base + i_imm;
    assign jalr_target = {jalr_sum[`FETCH_XLEN-1:1], 1'b0};  // A JALR target never has bit 0 set.

endmodule

// File: src/muldiv_timer.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module muldiv_timer (
    input  logic    clk,
    input  logic    rst_n,
    muldiv_if.timer md
);

    localparam int MAX_CYCLES = (`FETCH_DIV_CYCLES > `FETCH_MUL_CYCLES) ?
                                `FETCH_DIV_CYCLES : `FETCH_MUL_CYCLES;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

    logic [CNT_W-1:0] count_q;
    logic             finish_q;

    // ==================================================
    // Occupancy counter
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q  <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= (count_q == CNT_W'(1));  // Last counted cycle.
            if (md.start_mul) begin
                count_q <= CNT_W'(`FETCH_MUL_CYCLES);
            end else if (md.start_div) begin
                count_q <= CNT_W'(`FETCH_DIV_CYCLES);
            end else if (count_q != '0) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    assign md.busy   = (count_q != '0);
    assign md.finish = finish_q;

endmodule

// File: src/imem_port.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module imem_port (
    input  logic                   clk,
    input  logic                   rst_n,
    fetch_if.port                  fetch,
    output logic                   mem_req,
    output logic [`FETCH_XLEN-1:0] mem_addr,
    input  logic                   mem_ack,
    input  logic [`FETCH_XLEN-1:0] mem_rdata,
    output logic                   fetched_valid,
    output logic [`FETCH_XLEN-1:0] fetched_pc,
    output logic [`FETCH_XLEN-1:0] fetched_instr
);

    logic                   done_q;
    logic [`FETCH_XLEN-1:0] instr_q;
    logic                   beat;

    assign beat = mem_req & mem_ack;  // Read completes in this cycle.

    // ==================================================
    // Request handshake
    // ==================================================

    // The request stays up until the memory acknowledges it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= beat;
            if (fetch.fetch_go) begin
                mem_req <= 1'b1;
            end else if (beat) begin
                mem_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.fetch_go) begin
            mem_addr <= fetch.fetch_pc;  // Held until the next read opens.
        end
        if (beat) begin
            instr_q <= mem_rdata;
        end
    end

    assign fetch.fetch_done  = done_q;
    assign fetch.fetch_instr = instr_q;

    // The address register still holds the PC of the read that just finished.
    assign fetched_valid = done_q;
    assign fetched_pc    = mem_addr;
    assign fetched_instr = instr_q;

endmodule

// File: src/pc_sequencer.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pc_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    fetch_if.seq                     fetch,
    muldiv_if.seq                    md,
    input  fetch_pkg::instr_class_e  cls,
    input  logic [`FETCH_XLEN-1:0]   jal_target,
    input  logic [`FETCH_XLEN-1:0]   jalr_target,
    input  logic                     redirect_valid,
    input  logic [`FETCH_XLEN-1:0]   redirect_pc,
    input  logic                     stall
);

    localparam logic [`FETCH_XLEN-1:0] PC_STEP = 4;

    logic [`FETCH_XLEN-1:0] pc_q;
    logic                   read_open;    // A read is in flight at the memory port.
    logic                   jalr_dly;     // JALR waits here one cycle for its base.
    logic                   md_wait;      // Waiting for the multiply or divide timer.
    logic                   pend_valid;
    logic [`FETCH_XLEN-1:0] pend_pc;
    logic                   idle;
    logic                   redir_hit;
    logic [`FETCH_XLEN-1:0] redir_target;
    logic                   take_md;
    logic                   consume;

    // A fresh redirect beats one that was stored earlier.
    assign redir_hit    = redirect_valid | pend_valid;
    assign redir_target = redirect_valid ? redirect_pc : pend_pc;

    assign idle    = ~read_open & ~jalr_dly & ~md_wait;
    assign consume = idle | fetch.fetch_done | jalr_dly | (md_wait & md.finish);

    assign fetch.fetch_go = idle & ~stall & ~redirect_valid & ~md.busy;
    assign fetch.fetch_pc = pc_q;

    assign take_md      = fetch.fetch_done & ~redir_hit;
    assign md.start_mul = take_md & (cls == fetch_pkg::MUL);
    assign md.start_div = take_md & (cls == fetch_pkg::DIV);

    // ==================================================
    // Next-PC decision
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q       <= `FETCH_RESET_PC;
            read_open  <= 1'b0;
            jalr_dly   <= 1'b0;
            md_wait    <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            if (fetch.fetch_go) begin
                read_open <= 1'b1;
            end
            if (fetch.fetch_done) begin
                read_open <= 1'b0;
                if (redir_hit) begin
                    pc_q <= redir_target;
                end else begin
                    case (cls)
                        fetch_pkg::JALR: jalr_dly <= 1'b1;
                        fetch_pkg::JAL:  pc_q <= jal_target;
                        fetch_pkg::MUL,
                        fetch_pkg::DIV:  md_wait <= 1'b1;
                        default:         pc_q <= pc_q + PC_STEP;
                    endcase
                end
            end else if (jalr_dly) begin
                jalr_dly <= 1'b0;
                pc_q     <= redir_hit ? redir_target : jalr_target;
            end else if (md_wait) begin
                if (md.finish) begin
                    md_wait <= 1'b0;
                    pc_q    <= redir_hit ? redir_target : pc_q + PC_STEP;
                end
            end else if (redirect_valid) begin
                pc_q <= redirect_pc;                 // Idle, so the redirect applies now.
            end
            if (consume) begin
                pend_valid <= 1'b0;
            end else if (redirect_valid) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            pend_pc <= redirect_pc;
        end
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   mem_req,
    output logic [`FETCH_XLEN-1:0] mem_addr,
    input  logic                   mem_ack,
    input  logic [`FETCH_XLEN-1:0] mem_rdata,
    input  logic                   redirect_valid,
    input  logic [`FETCH_XLEN-1:0] redirect_pc,
    input  logic                   stall,
    input  logic [`FETCH_XLEN-1:0] jalr_base,
    output logic                   fetched_valid,
    output logic [`FETCH_XLEN-1:0] fetched_pc,
    output logic [`FETCH_XLEN-1:0] fetched_instr
);

    fetch_pkg::instr_class_e cls;
    logic [`FETCH_XLEN-1:0]  jal_target;
    logic [`FETCH_XLEN-1:0]  jalr_target;

    fetch_if  fetch_i ();
    muldiv_if md_i ();

    // ==================================================
    // Fetch pipeline
    // ==================================================

    pc_sequencer u_pc_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch          (fetch_i),
        .md             (md_i),
        .cls            (cls),
        .jal_target     (jal_target),
        .jalr_target    (jalr_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .stall          (stall)
    );

    imem_port u_imem_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch         (fetch_i),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .fetched_valid (fetched_valid),
        .fetched_pc    (fetched_pc),
        .fetched_instr (fetched_instr)
    );

    // The decoder sees the word and address of the last completed read.
    fetch_decode u_fetch_decode (
        .instr       (fetch_i.fetch_instr),
        .pc          (fetched_pc),
        .jalr_base   (jalr_base),
        .cls         (cls),
        .jal_target  (jal_target),
        .jalr_target (jalr_target)
    );

    muldiv_timer u_muldiv_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .md    (md_i)
    );

endmodule

// File: tb/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int TOTAL_FETCHES = 40;
    localparam int WORST_LAT     = `FETCH_DIV_CYCLES + 24;  // Includes memory wait and stall holds.

    logic        clk;
    logic        rst_n;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        stall;
    logic [31:0] jalr_base;
    logic        fetched_valid;
    logic [31:0] fetched_pc;
    logic [31:0] fetched_instr;

    logic [31:0] mem [logic [31:0]];
    integer      seed = 5;
    int          wait_left = -1;
    int          errors = 0;
    int          done_cnt = 0;
    int          gap_cnt = 0;
    int          min_gap = 0;
    logic        open_rd = 1'b0;
    logic [31:0] exp_pc = `FETCH_RESET_PC;
    logic        redir_pend = 1'b0;
    logic [31:0] redir_tgt;

    fetch_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Memory model and reference PC model
    // ==================================================

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return {a[26:2] ^ a[31:7], 7'b0010011};  // Unloaded words are addi-like.
    endfunction

    function automatic logic [31:0] predict_next(input logic [31:0] pc, input logic [31:0] w);
        logic [31:0] sum;
        if (w[6:0] == 7'b1101111) begin
            return pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        if (w[6:0] == 7'b1100111) begin
            sum = jalr_base + {{20{w[31]}}, w[31:20]};
            return sum & ~32'h1;
        end
        return pc + 32'd4;
    endfunction

    function automatic int occupancy(input logic [31:0] w);
        if (w[6:0] != 7'b0110011 || w[31:25] != 7'b0000001) return 0;
        return w[14] ? `FETCH_DIV_CYCLES + 2 : `FETCH_MUL_CYCLES + 2;
    endfunction

    always @(negedge clk) begin
        if (mem_ack) begin
            mem_ack   = 1'b0;
            wait_left = -1;
        end else if (mem_req) begin
            if (wait_left < 0) wait_left = $random(seed) & 3;
            if (wait_left == 0) begin
                mem_ack   = 1'b1;
                mem_rdata = mem_read(mem_addr);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_req && !open_rd) begin
                open_rd = 1'b1;
                a_addr: assert (mem_addr == exp_pc) else begin
                    errors++;
                    $display("** Error: mem_addr = %h, expected %h", mem_addr, exp_pc);
                end
                a_gap: assert (gap_cnt >= min_gap) else begin
                    errors++;
                    $display("mem_req rose %0d cycles after a multiply or divide", gap_cnt);
                end
            end
            if (fetched_valid) begin
                a_pc: assert (fetched_pc == exp_pc) else begin
                    errors++;
                    $display("** Error: fetched_pc = %h, expected %h", fetched_pc, exp_pc);
                end
                a_data: assert (fetched_instr == mem_read(exp_pc)) else begin
                    errors++;
                    $display("** Error: fetched_instr = %h, expected %h",
                             fetched_instr, mem_read(exp_pc));
                end
                min_gap = occupancy(mem_read(exp_pc));
                exp_pc  = redir_pend ? redir_tgt : predict_next(exp_pc, mem_read(exp_pc));
                redir_pend = 1'b0;
                open_rd  = 1'b0;
                gap_cnt  = 0;
                done_cnt = done_cnt + 1;
            end else begin
                gap_cnt = gap_cnt + 1;
            end
        end
    end

    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && $past(mem_req)) |-> $stable(mem_addr))
        else begin
            errors++;
            $display("mem_addr changed while mem_req waited for mem_ack");
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !$past(stall))
        else begin
            errors++;
            $display("mem_req rose while stall was high");
        end

    a_ack_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && mem_ack) |=> fetched_valid)
        else begin
            errors++;
            $display("fetched_valid missing after mem_ack");
        end

    a_valid_ack: assert property (@(posedge clk) disable iff (!rst_n)
        fetched_valid |-> $past(mem_req && mem_ack))
        else begin
            errors++;
            $display("fetched_valid pulsed without a mem_ack");
        end

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic run_fetches(input int n);
        int target;
        target = done_cnt + n;
        while (done_cnt < target) @(negedge clk);
    endtask

    task automatic wait_open_read();
        @(negedge clk);
        while (!mem_req) @(negedge clk);
    endtask

    task automatic pulse_redirect(input logic [31:0] tgt, input logic idle);
        redirect_valid = 1'b1;
        redirect_pc    = tgt;
        if (idle) exp_pc = tgt;  // Takes effect before the next read.
        else begin
            redir_pend = 1'b1;
            redir_tgt  = tgt;
        end
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic report(input string name, input int errs_before);
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int e;
        rst_n = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        stall = 1'b0;
        jalr_base = 32'h8000_0200;
        mem[32'h8000_0000] = {12'h001, 5'd0, 3'b000, 5'd1, 7'b0010011};
        mem[32'h8000_0004] = {12'h002, 5'd0, 3'b000, 5'd2, 7'b0010011};
        mem[32'h8000_0008] = {12'h003, 5'd0, 3'b000, 5'd3, 7'b0010011};
        mem[32'h8000_000c] = {7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011};  // mul
        mem[32'h8000_0010] = {12'h004, 5'd0, 3'b000, 5'd4, 7'b0010011};
        mem[32'h8000_0014] = {7'b0000001, 5'd2, 5'd1, 3'b100, 5'd3, 7'b0110011};  // div
        mem[32'h8000_0018] = {1'b0, 10'h020, 1'b0, 8'h00, 5'd1, 7'b1101111};     // jal +0x40
        mem[32'h8000_0058] = {12'h021, 5'd1, 3'b000, 5'd1, 7'b1100111};          // jalr +0x21
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        e = errors;
        run_fetches(4);
        report("plain stream", e);
        e = errors;
        run_fetches(3);
        report("multiply and divide", e);
        e = errors;
        run_fetches(2);
        report("jal and jalr", e);

        e = errors;
        wait_open_read();
        stall = 1'b1;
        run_fetches(1);
        repeat (6) @(negedge clk);
        stall = 1'b0;
        run_fetches(2);
        report("stall", e);

        e = errors;
        wait_open_read();
        pulse_redirect(32'h8000_0000, 1'b0);
        run_fetches(2);
        wait_open_read();
        stall = 1'b1;
        run_fetches(1);
        repeat (2) @(negedge clk);
        pulse_redirect(32'h8000_0300, 1'b1);
        stall = 1'b0;
        run_fetches(2);
        report("redirect", e);

        e = errors;
        run_fetches(20);
        report("long stream", e);

        $display("%0d fetches, %0d errors", done_cnt, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TOTAL_FETCHES * WORST_LAT * CLK_PERIOD);
        $display("timeout, the fetch stream stopped");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/fetch_pkg.sv
src/fetch_if.sv
src/fetch_decode.sv
src/muldiv_timer.sv
src/imem_port.sv
src/pc_sequencer.sv
src/fetch_top.sv
tb/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
